// ==== hpm.f ====
+incdir+source
source/hpm_event_pkg.sv
source/hpm_csr_pkg.sv
source/hpm_event_map.sv
source/hpm_counter.sv
source/hpm_counter_bank.sv
source/hpm_csr_port.sv
source/hpm_top.sv
verif/hpm_assert.sv
verif/hpm_tb.sv

// ==== run_hpm.sh ====
#!/bin/sh
# build the hpm testbench with Verilator, run it and check the log
verilator --binary --timing --assert --top-module hpm_tb -f hpm.f -o hpm_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/hpm_sim > hpm_sim.log 2>&1
cat hpm_sim.log

grep -q "Simulation finished: PASS" hpm_sim.log \
    && { echo "run_hpm: passed"; exit 0; } \
    || { echo "run_hpm: failed"; exit 1; }

// ==== verif/hpm_tb.sv ====
// ------------------------------
// hpm testbench
// directed tests of the performance monitor through
// its CSR port and its event flag inputs
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "hpm_settings.svh"

module hpm_tb;
    import hpm_event_pkg::*;
    import hpm_csr_pkg::*;

    // cycle budget with up to 8 pulses per burst
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = 30 + 160 + 40 + 60 + 30 + 40;  // six tests in run order
    localparam int MARGIN       = 100;

    logic                     clk;
    logic                     rstn;
    logic [`HPM_NUM_EVENTS:0] evt_flags;    // indexed by event number with bit 0 unused
    logic                     retire;
    logic                     csr_re;
    logic                     csr_we;
    hpm_csr_addr_t            csr_addr;
    hpm_csr_data_t            csr_wdata;
    hpm_csr_data_t            csr_rdata;
    logic                     csr_rvalid;
    logic                     ovf_irq;
    int                       errors;
    int                       checks;
    int                       tests;

    hpm_top uut (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .branch_miss_i  (evt_flags[1]),
        .is_branch_i    (evt_flags[2]),
        .branch_taken_i (evt_flags[3]),
        .stall_if_i     (evt_flags[4]),
        .stall_id_i     (evt_flags[5]),
        .stall_exe_i    (evt_flags[6]),
        .icache_req_i   (evt_flags[7]),
        .icache_miss_i  (evt_flags[8]),
        .dcache_load_i  (evt_flags[9]),
        .dcache_store_i (evt_flags[10]),
        .dcache_miss_i  (evt_flags[11]),
        .itlb_miss_i    (evt_flags[12]),
        .dtlb_miss_i    (evt_flags[13]),
        .data_depend_i  (evt_flags[14]),
        .retire_i       (retire),
        .csr_re_i       (csr_re),
        .csr_we_i       (csr_we),
        .csr_addr_i     (csr_addr),
        .csr_wdata_i    (csr_wdata),
        .csr_rdata_o    (csr_rdata),
        .csr_rvalid_o   (csr_rvalid),
        .ovf_irq_o      (ovf_irq)
    );

    always #5 clk = ~clk;    // 10 ns period

    // ------------------------------
    // bus and flag drivers that start and end on a falling edge
    // ------------------------------
    task automatic write_csr(input hpm_csr_addr_t addr, input hpm_csr_data_t value);
        csr_we    = 1'b1;
        csr_addr  = addr;
        csr_wdata = value;
        @(negedge clk);
        csr_we    = 1'b0;    // write lands at the edge just passed
    endtask

    task automatic read_csr(input hpm_csr_addr_t addr, output hpm_csr_data_t value);
        int wait_cnt;
        wait_cnt = 0;
        csr_re   = 1'b1;
        csr_addr = addr;
        @(negedge clk);
        csr_re   = 1'b0;
        while (!csr_rvalid && wait_cnt < 8) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (csr_rvalid) begin
            value = csr_rdata;
        end else begin
            $display("read of CSR %h at %0t got no response", addr, $time);
            errors++;
            value = '0;
        end
    endtask

    task automatic pulse_event(input logic [3:0] ev, input int unsigned n);
        for (int unsigned i = 0; i < n; i++) begin
            evt_flags[ev] = 1'b1;
            @(negedge clk);
            evt_flags[ev] = 1'b0;    // one idle cycle between pulses
            @(negedge clk);
        end
    endtask

    task automatic pulse_retire(input int unsigned n);
        for (int unsigned i = 0; i < n; i++) begin
            retire = 1'b1;
            @(negedge clk);
            retire = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // ------------------------------
    // compare and report
    // ------------------------------
    task automatic compare_data(input string name, input hpm_csr_data_t got,
                                input hpm_csr_data_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s read %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        tests++;
        if (errors == start_err) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - start_err);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic reset_values();
        int            start_err;
        hpm_csr_data_t value;
        start_err = errors;
        read_csr(CSR_MINSTRET, value);
        compare_data("minstret", value, '0);
        for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
            read_csr(CSR_MHPMCOUNTER3 + hpm_csr_addr_t'(k), value);
            compare_data("mhpmcounter", value, '0);
            read_csr(CSR_MHPMEVENT3 + hpm_csr_addr_t'(k), value);
            compare_data("mhpmevent", value, '0);
        end
        read_csr(CSR_MCOUNTINHIBIT, value);
        compare_data("mcountinhibit", value, '0);
        compare_bit("ovf_irq_o", ovf_irq, 1'b0);
        report_test("reset values", start_err);
    endtask

    task automatic event_counting();
        int            start_err;
        int unsigned   n;
        logic [3:0]    ev;
        hpm_csr_data_t value;
        start_err = errors;
        for (int j = 0; j < `HPM_NUM_COUNTERS; j++) begin
            ev = 4'(1 + $urandom % `HPM_NUM_EVENTS);
            n  = 1 + $urandom % 8;
            for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin   // only counter j listens
                write_csr(CSR_MHPMEVENT3 + hpm_csr_addr_t'(k),
                          (k == j) ? hpm_csr_data_t'(ev) : '0);
                write_csr(CSR_MHPMCOUNTER3 + hpm_csr_addr_t'(k), '0);
            end
            pulse_event(ev, n);
            wait_cycles(4);    // flag reaches the counter two edges later
            for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
                read_csr(CSR_MHPMCOUNTER3 + hpm_csr_addr_t'(k), value);
                compare_data("mhpmcounter", value, (k == j) ? hpm_csr_data_t'(n) : '0);
            end
        end
        report_test("event counting", start_err);
    endtask

    task automatic retire_and_cycle();
        int            start_err;
        int unsigned   n;
        hpm_csr_data_t value;
        hpm_csr_data_t cycle_a;
        start_err = errors;
        n = 1 + $urandom % 8;
        write_csr(CSR_MINSTRET, '0);
        pulse_retire(n);
        wait_cycles(4);
        read_csr(CSR_MINSTRET, value);
        compare_data("minstret", value, hpm_csr_data_t'(n));
        read_csr(CSR_MCYCLE, cycle_a);
        wait_cycles(5);
        read_csr(CSR_MCYCLE, value);
        compare_bit("mcycle increased", value > cycle_a, 1'b1);
        report_test("retire and cycle", start_err);
    endtask

    task automatic inhibit_control();
        int            start_err;
        int unsigned   n;
        logic [3:0]    ev;
        hpm_csr_data_t first;
        hpm_csr_data_t value;
        start_err = errors;
        ev = 4'(1 + $urandom % `HPM_NUM_EVENTS);
        n  = 1 + $urandom % 8;
        write_csr(CSR_MHPMEVENT3 + 12'd2, hpm_csr_data_t'(ev));   // hpm5 on bit 5
        write_csr(CSR_MHPMCOUNTER3 + 12'd2, '0);
        write_csr(CSR_MCOUNTINHIBIT, 64'h20);
        read_csr(CSR_MCOUNTINHIBIT, value);
        compare_data("mcountinhibit", value, 64'h20);
        read_csr(CSR_MHPMCOUNTER3 + 12'd2, first);
        compare_data("mhpmcounter5 cleared", first, '0);
        pulse_event(ev, n);
        wait_cycles(4);
        read_csr(CSR_MHPMCOUNTER3 + 12'd2, value);
        compare_data("mhpmcounter5 inhibited", value, first);
        write_csr(CSR_MCOUNTINHIBIT, '0);
        pulse_event(ev, n);
        wait_cycles(4);
        read_csr(CSR_MHPMCOUNTER3 + 12'd2, value);
        compare_data("mhpmcounter5 resumed", value, hpm_csr_data_t'(n));
        report_test("inhibit", start_err);
    endtask

    task automatic overflow_irq();
        int            start_err;
        logic [3:0]    ev;
        hpm_csr_data_t value;
        start_err = errors;
        ev = 4'(1 + $urandom % `HPM_NUM_EVENTS);
        write_csr(CSR_MHPMEVENT3 + 12'd1, hpm_csr_data_t'(ev));
        // two pulses from one below the 40-bit maximum wrap to zero
        write_csr(CSR_MHPMCOUNTER3 + 12'd1, hpm_csr_data_t'({`HPM_CNT_WIDTH{1'b1}}) - 64'd1);
        compare_bit("ovf_irq_o before wrap", ovf_irq, 1'b0);
        pulse_event(ev, 2);
        wait_cycles(4);
        read_csr(CSR_MHPMCOUNTER3 + 12'd1, value);
        compare_data("mhpmcounter4", value, '0);
        compare_bit("ovf_irq_o after wrap", ovf_irq, 1'b1);
        write_csr(CSR_MHPMCOUNTER3 + 12'd1, '0);    // rewrite clears the sticky flag
        compare_bit("ovf_irq_o after rewrite", ovf_irq, 1'b0);
        report_test("overflow", start_err);
    endtask

    task automatic register_readback();
        int            start_err;
        logic [3:0]    ev;
        hpm_csr_data_t value;
        start_err = errors;
        read_csr(12'h7C0, value);
        compare_data("unmapped 0x7c0", value, '0);
        read_csr(12'hB01, value);    // counter position 1 has no register
        compare_data("unmapped 0xb01", value, '0);
        for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
            ev = 4'(1 + $urandom % `HPM_NUM_EVENTS);
            write_csr(CSR_MHPMEVENT3 + hpm_csr_addr_t'(k), hpm_csr_data_t'(ev));
            read_csr(CSR_MHPMEVENT3 + hpm_csr_addr_t'(k), value);
            compare_data("mhpmevent", value, hpm_csr_data_t'(ev));
        end
        report_test("register readback", start_err);
    endtask

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        repeat (RESET_CYCLES + TEST_CYCLES + MARGIN) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(28));
        clk       = 1'b0;
        rstn      = 1'b0;
        evt_flags = '0;
        retire    = 1'b0;
        csr_re    = 1'b0;
        csr_we    = 1'b0;
        csr_addr  = '0;
        csr_wdata = '0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        reset_values();
        event_counting();
        retire_and_cycle();
        inhibit_control();
        overflow_irq();
        register_readback();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/hpm_assert.sv ====
// ------------------------------
// hpm assertions
// read response timing and overflow interrupt
// rules, bound into hpm_top
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "hpm_settings.svh"

module hpm_assert (
    input logic                        clk_i,
    input logic                        rstn_i,
    input logic                        csr_re_i,
    input logic                        csr_rvalid_i,
    input logic                        ovf_irq_i,
    input logic [63:0]                 cycle_i,
    input logic [63:0]                 instret_i,
    input hpm_csr_pkg::hpm_cnt_array_t hpm_cnt_i    // programmable counter values
);

    logic any_at_max;    // some counter wraps on its next increment

    always_comb begin
        any_at_max = (&cycle_i) | (&instret_i);
        for (int g = 0; g < `HPM_NUM_COUNTERS; g++) begin
            any_at_max = any_at_max | (&hpm_cnt_i[g]);
        end
    end

    // valid follows the read strobe by exactly one cycle
    rvalid_timing: assert property (@(posedge clk_i) disable iff (!rstn_i)
        csr_rvalid_i == $past(csr_re_i))
        else $error("csr_rvalid_o does not follow csr_re_i by one cycle");

    // the request only rises on the wrap of a counter that sat at its maximum
    irq_source: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(ovf_irq_i) |-> $past(any_at_max))
        else $error("ovf_irq_o rose with no counter wrapping");

    reset_state: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> (!csr_rvalid_i && !ovf_irq_i))
        else $error("outputs not idle after reset");

endmodule

bind hpm_top hpm_assert u_assert (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .csr_re_i     (csr_re_i),
    .csr_rvalid_i (csr_rvalid_o),
    .ovf_irq_i    (ovf_irq_o),
    .cycle_i      (cycle),
    .instret_i    (instret),
    .hpm_cnt_i    (hpm_cnt)
);

`default_nettype wire

// ==== source/hpm_top.sv ====
// ------------------------------
// hpm top
// hardware performance monitor: event map,
// counter bank and CSR port
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "hpm_settings.svh"

module hpm_top (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    // event flags
    input  logic                       branch_miss_i,
    input  logic                       is_branch_i,
    input  logic                       branch_taken_i,
    input  logic                       stall_if_i,
    input  logic                       stall_id_i,
    input  logic                       stall_exe_i,
    input  logic                       icache_req_i,
    input  logic                       icache_miss_i,
    input  logic                       dcache_load_i,
    input  logic                       dcache_store_i,
    input  logic                       dcache_miss_i,
    input  logic                       itlb_miss_i,
    input  logic                       dtlb_miss_i,
    input  logic                       data_depend_i,
    input  logic                       retire_i,
    // CSR access
    input  logic                       csr_re_i,
    input  logic                       csr_we_i,
    input  hpm_csr_pkg::hpm_csr_addr_t csr_addr_i,
    input  hpm_csr_pkg::hpm_csr_data_t csr_wdata_i,
    output hpm_csr_pkg::hpm_csr_data_t csr_rdata_o,
    output logic                       csr_rvalid_o,
    output logic                       ovf_irq_o      // counter overflow interrupt
);
    import hpm_event_pkg::*;
    import hpm_csr_pkg::*;

    hpm_event_vec_t               evt_vec;
    logic                         retire;
    hpm_cnt_mask_t                cnt_we;
    logic [`HPM_NUM_COUNTERS-1:0] evt_we;
    logic                         inhibit_we;
    hpm_csr_data_t                wdata;
    logic [63:0]                  cycle;
    logic [63:0]                  instret;
    hpm_cnt_array_t               hpm_cnt;
    hpm_sel_array_t               event_sel;
    hpm_cnt_mask_t                inhibit;

    hpm_event_map u_event_map (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .branch_miss_i  (branch_miss_i),
        .is_branch_i    (is_branch_i),
        .branch_taken_i (branch_taken_i),
        .stall_if_i     (stall_if_i),
        .stall_id_i     (stall_id_i),
        .stall_exe_i    (stall_exe_i),
        .icache_req_i   (icache_req_i),
        .icache_miss_i  (icache_miss_i),
        .dcache_load_i  (dcache_load_i),
        .dcache_store_i (dcache_store_i),
        .dcache_miss_i  (dcache_miss_i),
        .itlb_miss_i    (itlb_miss_i),
        .dtlb_miss_i    (dtlb_miss_i),
        .data_depend_i  (data_depend_i),
        .retire_i       (retire_i),
        .evt_vec_o      (evt_vec),
        .retire_o       (retire)
    );

    hpm_counter_bank u_counter_bank (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .evt_vec_i    (evt_vec),
        .retire_i     (retire),
        .cnt_we_i     (cnt_we),
        .evt_we_i     (evt_we),
        .inhibit_we_i (inhibit_we),
        .wdata_i      (wdata),
        .cycle_o      (cycle),
        .instret_o    (instret),
        .hpm_cnt_o    (hpm_cnt),
        .event_sel_o  (event_sel),
        .inhibit_o    (inhibit),
        .ovf_irq_o    (ovf_irq_o)
    );

    hpm_csr_port u_csr_port (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .csr_re_i     (csr_re_i),
        .csr_we_i     (csr_we_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .cycle_i      (cycle),
        .instret_i    (instret),
        .hpm_cnt_i    (hpm_cnt),
        .event_sel_i  (event_sel),
        .inhibit_i    (inhibit),
        .cnt_we_o     (cnt_we),
        .evt_we_o     (evt_we),
        .inhibit_we_o (inhibit_we),
        .wdata_o      (wdata),
        .csr_rdata_o  (csr_rdata_o),
        .csr_rvalid_o (csr_rvalid_o)
    );

endmodule

`default_nettype wire

// ==== source/hpm_csr_port.sv ====
// ------------------------------
// hpm CSR port
// decodes CSR strobes into counter, selector and
// inhibit writes, registers the read data
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "hpm_settings.svh"

module hpm_csr_port (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          csr_re_i,       // one-cycle read strobe
    input  logic                          csr_we_i,       // one-cycle write strobe
    input  hpm_csr_pkg::hpm_csr_addr_t    csr_addr_i,
    input  hpm_csr_pkg::hpm_csr_data_t    csr_wdata_i,
    input  logic [63:0]                   cycle_i,
    input  logic [63:0]                   instret_i,
    input  hpm_csr_pkg::hpm_cnt_array_t   hpm_cnt_i,
    input  hpm_csr_pkg::hpm_sel_array_t   event_sel_i,
    input  hpm_csr_pkg::hpm_cnt_mask_t    inhibit_i,
    output hpm_csr_pkg::hpm_cnt_mask_t    cnt_we_o,
    output logic [`HPM_NUM_COUNTERS-1:0]  evt_we_o,
    output logic                          inhibit_we_o,
    output hpm_csr_pkg::hpm_csr_data_t    wdata_o,
    output hpm_csr_pkg::hpm_csr_data_t    csr_rdata_o,
    output logic                          csr_rvalid_o
);
    import hpm_csr_pkg::*;

    hpm_csr_data_t rd_value;      // read mux, before the output register
    hpm_csr_data_t rdata_q;
    logic          rvalid_q;

    // ------------------------------
    // address decode
    // ------------------------------
    always_comb begin
        cnt_we_o     = '0;
        evt_we_o     = '0;
        inhibit_we_o = 1'b0;
        rd_value     = '0;        // unmapped addresses read zero
        if (csr_addr_i == CSR_MCYCLE) begin
            cnt_we_o[0] = csr_we_i;
            rd_value    = cycle_i;
        end
        if (csr_addr_i == CSR_MINSTRET) begin
            cnt_we_o[2] = csr_we_i;
            rd_value    = instret_i;
        end
        if (csr_addr_i == CSR_MCOUNTINHIBIT) begin
            inhibit_we_o = csr_we_i;
            rd_value     = hpm_csr_data_t'(inhibit_i);
        end
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
            if (csr_addr_i == CSR_MHPMCOUNTER3 + hpm_csr_addr_t'(i)) begin
                cnt_we_o[3+i] = csr_we_i;
                rd_value      = hpm_csr_data_t'(hpm_cnt_i[i]);   // zero-extend
            end
            if (csr_addr_i == CSR_MHPMEVENT3 + hpm_csr_addr_t'(i)) begin
                evt_we_o[i] = csr_we_i;
                rd_value    = hpm_csr_data_t'(event_sel_i[i]);
            end
        end
    end

    assign wdata_o = csr_wdata_i;   // write data is used in the strobe cycle

    // ------------------------------
    // read response, one cycle after the strobe
    // ------------------------------
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= csr_re_i;
        end
    end

    // value sampled before a same-cycle write lands
    always_ff @(posedge clk_i) begin
        if (csr_re_i) begin
            rdata_q <= rd_value;
        end
    end

    assign csr_rdata_o  = rdata_q;
    assign csr_rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// ==== source/hpm_counter_bank.sv ====
// ------------------------------
// hpm counter bank
// mcycle, minstret and the programmable counters with
// their event selectors, the mcountinhibit register
// and the overflow interrupt request
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "hpm_settings.svh"

module hpm_counter_bank (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  hpm_event_pkg::hpm_event_vec_t evt_vec_i,
    input  logic                          retire_i,
    input  hpm_csr_pkg::hpm_cnt_mask_t    cnt_we_i,       // one bit per counter position
    input  logic [`HPM_NUM_COUNTERS-1:0]  evt_we_i,       // selector writes
    input  logic                          inhibit_we_i,
    input  hpm_csr_pkg::hpm_csr_data_t    wdata_i,
    output logic [63:0]                   cycle_o,
    output logic [63:0]                   instret_o,
    output hpm_csr_pkg::hpm_cnt_array_t   hpm_cnt_o,
    output hpm_csr_pkg::hpm_sel_array_t   event_sel_o,
    output hpm_csr_pkg::hpm_cnt_mask_t    inhibit_o,
    output logic                          ovf_irq_o
);
    import hpm_event_pkg::*;
    import hpm_csr_pkg::*;

    hpm_sel_array_t                event_sel_q;
    hpm_cnt_mask_t                 inhibit_q;
    hpm_event_e                    sel_wdata;   // legalized selector value
    logic                          ovf_cycle;
    logic                          ovf_instret;
    logic [`HPM_NUM_COUNTERS-1:0]  ovf_hpm;

    // out-of-range event numbers fall back to "no event"
    assign sel_wdata = (wdata_i[3:0] > `HPM_NUM_EVENTS) ? EVT_NONE
                                                        : hpm_event_e'(wdata_i[3:0]);

    // ------------------------------
    // selector and inhibit registers
    // ------------------------------
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            event_sel_q <= '{default: EVT_NONE};
            inhibit_q   <= '0;
        end else begin
            for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
                if (evt_we_i[i]) begin
                    event_sel_q[i] <= sel_wdata;
                end
            end
            if (inhibit_we_i) begin
                inhibit_q <= wdata_i[$bits(hpm_cnt_mask_t)-1:0] & INHIBIT_WMASK;
            end
        end
    end

    // ------------------------------
    // counters
    // ------------------------------
    hpm_counter #(.cnt_t(logic [63:0])) u_mcycle (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .inc_i        (~inhibit_q[0]),             // every cycle unless inhibited
        .load_i       (cnt_we_i[0]),
        .load_value_i (wdata_i),
        .count_o      (cycle_o),
        .ovf_o        (ovf_cycle)
    );

    hpm_counter #(.cnt_t(logic [63:0])) u_minstret (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .inc_i        (retire_i & ~inhibit_q[2]),
        .load_i       (cnt_we_i[2]),
        .load_value_i (wdata_i),
        .count_o      (instret_o),
        .ovf_o        (ovf_instret)
    );

    for (genvar g = 0; g < `HPM_NUM_COUNTERS; g++) begin : g_hpm
        hpm_counter #(.cnt_t(hpm_cnt_t)) u_hpm (
            .clk_i        (clk_i),
            .rstn_i       (rstn_i),
            .inc_i        (evt_vec_i[event_sel_q[g]] & ~inhibit_q[3+g]),
            .load_i       (cnt_we_i[3+g]),
            .load_value_i (wdata_i[`HPM_CNT_WIDTH-1:0]),
            .count_o      (hpm_cnt_o[g]),
            .ovf_o        (ovf_hpm[g])
        );
    end

    assign event_sel_o = event_sel_q;
    assign inhibit_o   = inhibit_q;
    assign ovf_irq_o   = ovf_cycle | ovf_instret | (|ovf_hpm);   // level, any sticky flag

endmodule

`default_nettype wire

// ==== source/hpm_counter.sv ====
// ------------------------------
// hpm counter
// loadable wrapping counter with a sticky overflow
// flag, width taken from its type parameter
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module hpm_counter #(
    parameter type cnt_t = logic [63:0]
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic inc_i,           // count one this cycle
    input  logic load_i,          // CSR write, wins over inc_i
    input  cnt_t load_value_i,
    output cnt_t count_o,
    output logic ovf_o            // sticky until the next load
);

    cnt_t count_q;
    logic ovf_q;
    logic at_max;

    assign at_max = &count_q;     // next increment wraps to zero

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            count_q <= '0;
            ovf_q   <= 1'b0;
        end else if (load_i) begin
            count_q <= load_value_i;
            ovf_q   <= 1'b0;      // rewrite acknowledges the overflow
        end else if (inc_i) begin
            count_q <= count_q + 1'b1;
            if (at_max) begin
                ovf_q <= 1'b1;
            end
        end
    end

    assign count_o = count_q;
    assign ovf_o   = ovf_q;

endmodule

`default_nettype wire

// ==== source/hpm_event_map.sv ====
// ------------------------------
// hpm event map
// places the raw pipeline and memory flags at their
// event numbers and registers the vector and retire
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module hpm_event_map (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    // pipeline flags
    input  logic                          branch_miss_i,
    input  logic                          is_branch_i,
    input  logic                          branch_taken_i,
    input  logic                          stall_if_i,
    input  logic                          stall_id_i,
    input  logic                          stall_exe_i,
    // memory system flags
    input  logic                          icache_req_i,
    input  logic                          icache_miss_i,
    input  logic                          dcache_load_i,
    input  logic                          dcache_store_i,
    input  logic                          dcache_miss_i,
    input  logic                          itlb_miss_i,
    input  logic                          dtlb_miss_i,
    input  logic                          data_depend_i,
    input  logic                          retire_i,    // one instruction retired
    output hpm_event_pkg::hpm_event_vec_t evt_vec_o,
    output logic                          retire_o
);
    import hpm_event_pkg::*;

    hpm_event_vec_t evt_d;      // numbered flags this cycle
    hpm_event_vec_t evt_q;
    logic           retire_q;

    always_comb begin
        evt_d                   = '0;   // bit 0 is the idle selector
        evt_d[EVT_BRANCH_MISS]  = branch_miss_i;
        evt_d[EVT_IS_BRANCH]    = is_branch_i;
        evt_d[EVT_BRANCH_TAKEN] = branch_taken_i;
        evt_d[EVT_STALL_IF]     = stall_if_i;
        evt_d[EVT_STALL_ID]     = stall_id_i;
        evt_d[EVT_STALL_EXE]    = stall_exe_i;
        evt_d[EVT_ICACHE_REQ]   = icache_req_i;
        evt_d[EVT_ICACHE_MISS]  = icache_miss_i;
        evt_d[EVT_DCACHE_LOAD]  = dcache_load_i;
        evt_d[EVT_DCACHE_STORE] = dcache_store_i;
        evt_d[EVT_DCACHE_MISS]  = dcache_miss_i;
        evt_d[EVT_ITLB_MISS]    = itlb_miss_i;
        evt_d[EVT_DTLB_MISS]    = dtlb_miss_i;
        evt_d[EVT_DATA_DEPEND]  = data_depend_i;
    end

    // one register stage decouples the counters from the pipeline paths
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            evt_q    <= '0;
            retire_q <= 1'b0;
        end else begin
            evt_q    <= evt_d;
            retire_q <= retire_i;
        end
    end

    assign evt_vec_o = evt_q;
    assign retire_o  = retire_q;

endmodule

`default_nettype wire

// ==== source/hpm_csr_pkg.sv ====
// ------------------------------
// hpm CSR package
// counter CSR addresses, CSR data type,
// counter mask and counter array types
// ------------------------------
`default_nettype none

`include "hpm_settings.svh"

package hpm_csr_pkg;

    typedef logic [`HPM_CSR_ADDR_WIDTH-1:0] hpm_csr_addr_t;
    typedef logic [`HPM_XLEN-1:0]           hpm_csr_data_t;

    // bit layout of mcountinhibit: 0 cycle, 1 unused, 2 instret, 3..6 hpm3..hpm6
    typedef logic [`HPM_NUM_COUNTERS+2:0]   hpm_cnt_mask_t;

    typedef logic [`HPM_CNT_WIDTH-1:0]      hpm_cnt_t;   // one programmable counter

    typedef hpm_cnt_t [`HPM_NUM_COUNTERS-1:0]               hpm_cnt_array_t;
    typedef hpm_event_pkg::hpm_event_e [`HPM_NUM_COUNTERS-1:0] hpm_sel_array_t;

    // ------------------------------
    // machine counter addresses
    // ------------------------------
    localparam hpm_csr_addr_t CSR_MCYCLE        = 12'hB00;
    localparam hpm_csr_addr_t CSR_MINSTRET      = 12'hB02;
    localparam hpm_csr_addr_t CSR_MHPMCOUNTER3  = 12'hB03;   // up to 0xB06

    // ------------------------------
    // counter setup addresses
    // ------------------------------
    localparam hpm_csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
    localparam hpm_csr_addr_t CSR_MHPMEVENT3    = 12'h323;   // up to 0x326

    // unused bit 1 of mcountinhibit always reads zero
    localparam hpm_cnt_mask_t INHIBIT_WMASK = ~hpm_cnt_mask_t'(2);

endpackage

`default_nettype wire

// ==== source/hpm_event_pkg.sv ====
// ------------------------------
// hpm event package
// event numbering used by the event selectors
// and the numbered event vector type
// ------------------------------
`default_nettype none

`include "hpm_settings.svh"

package hpm_event_pkg;

    // event number as written into mhpmevent3..6
    typedef enum logic [3:0] {
        EVT_NONE         = 4'd0,   // selector idle, never counts
        EVT_BRANCH_MISS  = 4'd1,
        EVT_IS_BRANCH    = 4'd2,
        EVT_BRANCH_TAKEN = 4'd3,
        EVT_STALL_IF     = 4'd4,   // fetch stage stalled
        EVT_STALL_ID     = 4'd5,
        EVT_STALL_EXE    = 4'd6,
        EVT_ICACHE_REQ   = 4'd7,
        EVT_ICACHE_MISS  = 4'd8,
        EVT_DCACHE_LOAD  = 4'd9,
        EVT_DCACHE_STORE = 4'd10,
        EVT_DCACHE_MISS  = 4'd11,
        EVT_ITLB_MISS    = 4'd12,
        EVT_DTLB_MISS    = 4'd13,
        EVT_DATA_DEPEND  = 4'd14   // operand dependency stall
    } hpm_event_e;

    // one bit per event number, bit 0 stays zero
    typedef logic [`HPM_NUM_EVENTS:0] hpm_event_vec_t;

endpackage

`default_nettype wire

// ==== source/hpm_settings.svh ====
// ------------------------------
// hpm settings
// sizing of the hardware performance monitor:
// counter and event counts, counter and CSR widths
// ------------------------------
`ifndef HPM_SETTINGS_SVH
`define HPM_SETTINGS_SVH

// programmable counters, mhpmcounter3 up to mhpmcounter6
`define HPM_NUM_COUNTERS   4

// numbered events, 0 is reserved for "no event"
`define HPM_NUM_EVENTS     14

`define HPM_CNT_WIDTH      40   // width of one programmable counter

// CSR access
`define HPM_CSR_ADDR_WIDTH 12   // standard RISC-V CSR address space
`define HPM_XLEN           64   // CSR data width

`endif
